//--- Bender.yml
package:
  name: mmu

sources:
  # Design sources in compile order
  - files:
      - rtl/mmu_pkg.sv
      - rtl/mmu_req_stage.sv
      - rtl/mmu_tlb.sv
      - rtl/mmu_resp_stage.sv
      - rtl/mmu_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verification/mmu_asserts.sv
      - verification/mmu_tb.sv

//--- filelist.f
rtl/mmu_pkg.sv
rtl/mmu_req_stage.sv
rtl/mmu_tlb.sv
rtl/mmu_resp_stage.sv
rtl/mmu_top.sv
verification/mmu_asserts.sv
verification/mmu_tb.sv

//--- rtl/mmu_pkg.sv
package mmu_pkg;

    // Address geometry
    localparam int unsigned VADDR_SIZE       = 32;
    localparam int unsigned PADDR_SIZE       = 24;
    localparam int unsigned PAGE_OFFSET_SIZE = 12; // 4 KiB pages

    // Page numbers follow from the address widths
    localparam int unsigned VPN_SIZE = VADDR_SIZE - PAGE_OFFSET_SIZE; // 20 bits
    localparam int unsigned PPN_SIZE = PADDR_SIZE - PAGE_OFFSET_SIZE; // 12 bits

    // Page protection, also used as the requested access kind
    typedef enum logic [1:0] {
        R  = 2'b00,
        W  = 2'b01,
        EX = 2'b10,
        RW = 2'b11  // Stored protection only, never requested
    } page_perm_e;

    // Access size of a memory-stage request
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } access_size_e;

    // Registered request, as seen by the buffer and the response stage
    typedef struct packed {
        logic                        valid;
        logic [VPN_SIZE-1:0]         vpn;
        logic [PAGE_OFFSET_SIZE-1:0] offset;
        page_perm_e                  access;
        logic                        misaligned;
    } mmu_req_t;

    // Refill data and stored row; the valid bit lives in the buffer
    typedef struct packed {
        logic [VPN_SIZE-1:0] vpn;
        logic [PPN_SIZE-1:0] ppn;
        page_perm_e          perm;
    } tlb_entry_t;

    // Combinational lookup result
    typedef struct packed {
        logic                hit;
        logic [PPN_SIZE-1:0] ppn;
        page_perm_e          perm;
    } tlb_lookup_t;

endpackage : mmu_pkg

//--- rtl/mmu_req_stage.sv
`timescale 1ns/100ps

module mmu_req_stage
    import mmu_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  logic                  req_i,    // One-cycle request strobe
    input  logic [VADDR_SIZE-1:0] vaddr_i,
    input  page_perm_e            access_i, // R, W or EX
    input  access_size_e          size_i,

    output mmu_req_t              req_o
);

    mmu_req_t req_d;
    mmu_req_t req_q;
    logic     misaligned;

    // Alignment check against the access size
    always_comb begin
        unique case (size_i)
            HALF:    misaligned = vaddr_i[0];
            WORD:    misaligned = |vaddr_i[1:0];
            default: misaligned = 1'b0; // Byte accesses are always aligned
        endcase
    end

    // Split the virtual address into page number and offset
    always_comb begin
        req_d.valid      = req_i;
        req_d.vpn        = vaddr_i[VADDR_SIZE-1:PAGE_OFFSET_SIZE];
        req_d.offset     = vaddr_i[PAGE_OFFSET_SIZE-1:0];
        req_d.access     = access_i;
        req_d.misaligned = misaligned;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= req_d.valid; // Drops again in a cycle without req_i
        end

        // Payload only moves when a request is taken
        if (req_i) begin
            req_q.vpn        <= req_d.vpn;
            req_q.offset     <= req_d.offset;
            req_q.access     <= req_d.access;
            req_q.misaligned <= req_d.misaligned;
        end
    end

    assign req_o = req_q;

endmodule : mmu_req_stage

//--- rtl/mmu_resp_stage.sv
`timescale 1ns/100ps

module mmu_resp_stage
    import mmu_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  mmu_req_t              req_i,          // Request in its lookup cycle
    input  tlb_lookup_t           lookup_i,       // Combinational buffer result

    output logic                  resp_valid_o,
    output logic                  hit_o,
    output logic                  miss_o,
    output logic                  pp_exception_o, // Page protection fault
    output logic                  misaligned_o,
    output logic [PADDR_SIZE-1:0] paddr_o
);

    logic                  allowed;
    logic                  hit;
    logic [PADDR_SIZE-1:0] paddr;

    // Exact match, or RW covering plain reads and writes
    always_comb begin
        allowed = (lookup_i.perm == req_i.access)
               || ((lookup_i.perm == RW) && ((req_i.access == R) || (req_i.access == W)));
    end

    // A misaligned request ignores the lookup entirely
    assign hit   = lookup_i.hit && !req_i.misaligned;
    assign paddr = (hit && allowed) ? {lookup_i.ppn, req_i.offset} : '0;

    always_ff @(posedge clk_i) begin
        if (reset_i || !req_i.valid) begin
            resp_valid_o   <= 1'b0;
            hit_o          <= 1'b0;
            miss_o         <= 1'b0;
            pp_exception_o <= 1'b0;
            misaligned_o   <= 1'b0;
            paddr_o        <= '0;
        end else begin
            resp_valid_o   <= 1'b1;
            hit_o          <= hit;
            miss_o         <= !lookup_i.hit && !req_i.misaligned;
            pp_exception_o <= hit && !allowed;
            misaligned_o   <= req_i.misaligned;
            paddr_o        <= paddr;
        end
    end

endmodule : mmu_resp_stage

//--- rtl/mmu_tlb.sv
`timescale 1ns/100ps

module mmu_tlb
    import mmu_pkg::*;
#(
    parameter int unsigned NUM_ENTRIES = 4
) (
    input  logic                clk_i,
    input  logic                reset_i,

    input  logic [VPN_SIZE-1:0] vpn_i,          // Page number of the request in flight

    input  logic                refill_i,       // Write one entry at the round-robin slot
    input  tlb_entry_t          refill_entry_i,
    input  logic                invalidate_i,   // Flush all entries

    output tlb_lookup_t         lookup_o
);

    localparam int unsigned IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_ENTRIES - 1);

    tlb_entry_t             rows_q [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] valid_q;
    logic [IDX_W-1:0]       rr_ptr_q;           // Next slot to be replaced
    logic [IDX_W-1:0]       rr_ptr_next;

    logic [NUM_ENTRIES-1:0] hit_vec;
    logic [IDX_W-1:0]       hit_idx;
    logic                   hit;
    logic                   refill_we;

    // Associative compare against every valid row
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            hit_vec[i] = valid_q[i] && (rows_q[i].vpn == vpn_i);
        end
        hit = |hit_vec;
    end

    // Hit vector to row index where the lowest index wins if more than one matches
    always_comb begin
        hit_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    // Read port; ppn and perm are don't-care on a miss
    always_comb begin
        lookup_o.hit  = hit;
        lookup_o.ppn  = rows_q[hit_idx].ppn;
        lookup_o.perm = rows_q[hit_idx].perm;
    end

    // Invalidate wins, so a refill in the same cycle is dropped
    assign refill_we = refill_i && !invalidate_i;

    // Round-robin advance with wrap for any entry count
    always_comb begin
        if (rr_ptr_q == LAST_IDX) begin
            rr_ptr_next = '0;
        end else begin
            rr_ptr_next = rr_ptr_q + 1'b1;
        end
    end

    // Valid bits and replacement pointer
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (invalidate_i) begin
            valid_q  <= '0;
            rr_ptr_q <= '0; // Next refill lands in entry 0
        end else if (refill_we) begin
            valid_q[rr_ptr_q] <= 1'b1;
            rr_ptr_q          <= rr_ptr_next;
        end
    end

    // Row storage
    always_ff @(posedge clk_i) begin
        if (refill_we) begin
            rows_q[rr_ptr_q] <= refill_entry_i; // Protection is taken as given
        end
    end

endmodule : mmu_tlb

//--- rtl/mmu_top.sv
`timescale 1ns/100ps

module mmu_top
    import mmu_pkg::*;
#(
    parameter int unsigned NUM_ENTRIES = 4
) (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Memory-stage request
    input  logic                  req_i,
    input  logic [VADDR_SIZE-1:0] vaddr_i,
    input  page_perm_e            access_i,
    input  access_size_e          size_i,

    // Software refill and flush
    input  logic                  refill_i,
    input  tlb_entry_t            refill_entry_i,
    input  logic                  invalidate_i,

    // Translation result, two cycles after req_i
    output logic                  resp_valid_o,
    output logic                  hit_o,
    output logic                  miss_o,
    output logic                  pp_exception_o,
    output logic                  misaligned_o,
    output logic [PADDR_SIZE-1:0] paddr_o
);

    mmu_req_t    req_q;  // Registered request, shared by buffer and response stage
    tlb_lookup_t lookup;

    mmu_req_stage i_mmu_req_stage (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .vaddr_i  (vaddr_i),
        .access_i (access_i),
        .size_i   (size_i),
        .req_o    (req_q)
    );

    mmu_tlb #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_mmu_tlb (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .vpn_i          (req_q.vpn),
        .refill_i       (refill_i),
        .refill_entry_i (refill_entry_i),
        .invalidate_i   (invalidate_i),
        .lookup_o       (lookup)
    );

    mmu_resp_stage i_mmu_resp_stage (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_i          (req_q),
        .lookup_i       (lookup),
        .resp_valid_o   (resp_valid_o),
        .hit_o          (hit_o),
        .miss_o         (miss_o),
        .pp_exception_o (pp_exception_o),
        .misaligned_o   (misaligned_o),
        .paddr_o        (paddr_o)
    );

endmodule : mmu_top

//--- verification/mmu_asserts.sv
`timescale 1ns/100ps

module mmu_asserts
    import mmu_pkg::*;
(
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  resp_valid_i,
    input logic                  hit_i,
    input logic                  miss_i,
    input logic                  pp_exception_i,
    input logic                  misaligned_i,
    input logic [PADDR_SIZE-1:0] paddr_i
);

    logic any_flag;

    assign any_flag = hit_i || miss_i || pp_exception_i || misaligned_i;

    a_hit_miss_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(hit_i && miss_i))
        else $error("hit_o and miss_o are high together");

    // A response lasts one cycle unless the next request follows right away
    a_resp_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_valid_i |=> (!resp_valid_i || $onehot({hit_i, miss_i, misaligned_i})))
        else $error("resp_valid_o held without a well formed next response");

    a_quiet_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        !resp_valid_i |-> !any_flag)
        else $error("response flag high without resp_valid_o");

    a_pp_needs_hit: assert property (@(posedge clk_i) disable iff (reset_i)
        pp_exception_i |-> hit_i)
        else $error("pp_exception_o high without hit_o");

    a_reset_quiet: assert property (@(posedge clk_i)
        reset_i |=> !(resp_valid_i || any_flag || (paddr_i != '0)))
        else $error("response outputs not cleared by reset");

endmodule : mmu_asserts

bind mmu_top mmu_asserts i_mmu_asserts (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .resp_valid_i   (resp_valid_o),
    .hit_i          (hit_o),
    .miss_i         (miss_o),
    .pp_exception_i (pp_exception_o),
    .misaligned_i   (misaligned_o),
    .paddr_i        (paddr_o)
);

//--- verification/mmu_tb.sv
`timescale 1ns/100ps

module mmu_tb
    import mmu_pkg::*;
();

    localparam int unsigned NUM_ENTRIES = 4;
    localparam int unsigned LATENCY     = 2;
    localparam int unsigned TIMEOUT     = 100;
    localparam logic [VPN_SIZE-1:0] POOL_BASE = 20'h70000; // Pages used by the random test

    // Expected response of one request
    typedef struct packed {
        logic                  hit;
        logic                  miss;
        logic                  pp_exception;
        logic                  misaligned;
        logic [PADDR_SIZE-1:0] paddr;
    } resp_t;

    logic                  clk_i;
    logic                  reset_i;
    logic                  req_i;
    logic [VADDR_SIZE-1:0] vaddr_i;
    page_perm_e            access_i;
    access_size_e          size_i;
    logic                  refill_i;
    tlb_entry_t            refill_entry_i;
    logic                  invalidate_i;
    logic                  resp_valid_o;
    logic                  hit_o;
    logic                  miss_o;
    logic                  pp_exception_o;
    logic                  misaligned_o;
    logic [PADDR_SIZE-1:0] paddr_o;

    tlb_entry_t             shadow_rows [NUM_ENTRIES]; // Reference copy of the buffer
    logic [NUM_ENTRIES-1:0] shadow_valid;
    int unsigned            shadow_ptr;

    resp_t       exp_q[$];
    int unsigned edge_q[$];  // Edge at which each request was driven
    string       name_q[$];
    string       test_name    = "init";
    int unsigned edge_cnt     = 0;
    int unsigned mismatch_cnt = 0;
    int unsigned fail_cnt     = 0;
    integer      seed         = 32'hdc7aa09e;

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        edge_cnt <= edge_cnt + 1;
    end

    mmu_top #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_mmu_top (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_i          (req_i),
        .vaddr_i        (vaddr_i),
        .access_i       (access_i),
        .size_i         (size_i),
        .refill_i       (refill_i),
        .refill_entry_i (refill_entry_i),
        .invalidate_i   (invalidate_i),
        .resp_valid_o   (resp_valid_o),
        .hit_o          (hit_o),
        .miss_o         (miss_o),
        .pp_exception_o (pp_exception_o),
        .misaligned_o   (misaligned_o),
        .paddr_o        (paddr_o)
    );

    // Expected response from the shadow buffer and the protection rule
    function automatic resp_t ref_translate(logic [VADDR_SIZE-1:0] vaddr, page_perm_e access,
                                            access_size_e size);
        resp_t      r;
        logic       found;
        logic       ok;
        tlb_entry_t e;
        r     = '0;
        found = 1'b0;
        e     = '0;
        if ((size == HALF && vaddr[0]) || (size == WORD && vaddr[1:0] != 2'b00)) begin
            r.misaligned = 1'b1;
            return r;
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!found && shadow_valid[i]
                    && shadow_rows[i].vpn == vaddr[VADDR_SIZE-1:PAGE_OFFSET_SIZE]) begin
                found = 1'b1;
                e     = shadow_rows[i];
            end
        end
        if (!found) begin
            r.miss = 1'b1;
            return r;
        end
        case (e.perm)
            RW:      ok = (access != EX);   // Read and write, never execute
            default: ok = (e.perm == access);
        endcase
        r.hit          = 1'b1;
        r.pp_exception = !ok;
        r.paddr        = ok ? {e.ppn, vaddr[PAGE_OFFSET_SIZE-1:0]} : '0;
        return r;
    endfunction

    task automatic shadow_update(logic refill, tlb_entry_t entry, logic inval);
        if (inval) begin
            shadow_valid = '0;
            shadow_ptr   = 0;
        end else if (refill) begin
            shadow_rows[shadow_ptr]  = entry;
            shadow_valid[shadow_ptr] = 1'b1;
            shadow_ptr               = (shadow_ptr + 1) % NUM_ENTRIES;
        end
    endtask

    // One clock of stimulus where the model sees refills before a request of the same edge
    task automatic drive_cycle(logic req, logic [VADDR_SIZE-1:0] vaddr, page_perm_e access,
                               access_size_e size, logic refill, tlb_entry_t entry,
                               logic inval);
        @(posedge clk_i);
        req_i          <= req;
        vaddr_i        <= vaddr;
        access_i       <= access;
        size_i         <= size;
        refill_i       <= refill;
        refill_entry_i <= entry;
        invalidate_i   <= inval;
        shadow_update(refill, entry, inval);
        if (req) begin
            exp_q.push_back(ref_translate(vaddr, access, size));
            edge_q.push_back(edge_cnt);
            name_q.push_back(test_name);
        end
    endtask

    function automatic logic [VADDR_SIZE-1:0] page_addr(logic [VPN_SIZE-1:0] vpn,
                                                        logic [PAGE_OFFSET_SIZE-1:0] offset);
        return {vpn, offset};
    endfunction

    task automatic send_req(logic [VADDR_SIZE-1:0] vaddr, page_perm_e access,
                            access_size_e size);
        drive_cycle(1'b1, vaddr, access, size, 1'b0, '0, 1'b0);
    endtask

    task automatic send_refill(logic [VPN_SIZE-1:0] vpn, logic [PPN_SIZE-1:0] ppn,
                               page_perm_e perm);
        tlb_entry_t entry;
        entry.vpn  = vpn;
        entry.ppn  = ppn;
        entry.perm = perm;
        drive_cycle(1'b0, '0, R, BYTE, 1'b1, entry, 1'b0);
    endtask

    task automatic send_invalidate();
        drive_cycle(1'b0, '0, R, BYTE, 1'b0, '0, 1'b1);
    endtask

    // Idle the inputs and wait until every expected response was seen
    task automatic finish_test();
        int unsigned n;
        drive_cycle(1'b0, '0, R, BYTE, 1'b0, '0, 1'b0);
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(posedge clk_i);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d responses of test %s never arrived", exp_q.size(), test_name);
            fail_cnt++;
            exp_q.delete();
            edge_q.delete();
            name_q.delete();
        end
    endtask

    // Compare process sampling between edges
    always @(negedge clk_i) begin
        resp_t       exp;
        int unsigned drive_edge;
        string       tname;
        if (!reset_i && resp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: response after edge %0d without a pending request", edge_cnt - 1);
                fail_cnt++;
            end else begin
                exp        = exp_q.pop_front();
                drive_edge = edge_q.pop_front();
                tname      = name_q.pop_front();
                if (edge_cnt - 1 != drive_edge + LATENCY) begin
                    $display("MISMATCH %s latency: expected %0d actual %0d", tname, LATENCY,
                             edge_cnt - 1 - drive_edge);
                    mismatch_cnt++;
                end
                if (hit_o !== exp.hit) begin
                    $display("MISMATCH %s hit_o: expected %0b actual %0b", tname, exp.hit, hit_o);
                    mismatch_cnt++;
                end
                if (miss_o !== exp.miss) begin
                    $display("MISMATCH %s miss_o: expected %0b actual %0b", tname, exp.miss,
                             miss_o);
                    mismatch_cnt++;
                end
                if (pp_exception_o !== exp.pp_exception) begin
                    $display("MISMATCH %s pp_exception_o: expected %0b actual %0b", tname,
                             exp.pp_exception, pp_exception_o);
                    mismatch_cnt++;
                end
                if (misaligned_o !== exp.misaligned) begin
                    $display("MISMATCH %s misaligned_o: expected %0b actual %0b", tname,
                             exp.misaligned, misaligned_o);
                    mismatch_cnt++;
                end
                if (paddr_o !== exp.paddr) begin
                    $display("MISMATCH %s paddr_o: expected %06h actual %06h", tname, exp.paddr,
                             paddr_o);
                    mismatch_cnt++;
                end
            end
        end
    end

    initial begin
        logic [31:0]           ctl;
        logic [VADDR_SIZE-1:0] vaddr;
        tlb_entry_t            entry;
        reset_i        = 1'b1;
        req_i          = 1'b0;
        vaddr_i        = '0;
        access_i       = R;
        size_i         = BYTE;
        refill_i       = 1'b0;
        refill_entry_i = '0;
        invalidate_i   = 1'b0;
        shadow_valid   = '0;
        shadow_ptr     = 0;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;

        test_name = "reset_miss"; // Empty buffer after reset
        for (int k = 0; k < 8; k++) begin
            send_req($random(seed) & ~32'h3, R, WORD);
        end
        finish_test();

        test_name = "refill_hit";
        for (int k = 0; k < 4; k++) begin
            send_refill(20'h10000 + k[3:0], 12'ha00 + k[3:0], page_perm_e'(k[1:0]));
        end
        for (int k = 0; k < 4; k++) begin
            send_req(page_addr(20'h10000 + k[3:0], 12'($random(seed)) & 12'hffc),
                     (k == 1) ? W : ((k == 2) ? EX : R), WORD);
        end
        send_refill(20'h20000, 12'hb00, RW); // Replaces entry 0
        send_req(page_addr(20'h10000, 12'h010), R, WORD);
        send_req(page_addr(20'h10001, 12'h014), W, WORD);
        send_req(page_addr(20'h20000, 12'h018), W, WORD);
        finish_test();

        test_name = "perm_matrix";
        send_invalidate();
        for (int k = 0; k < 4; k++) begin
            send_refill(20'h30000 + k[3:0], 12'hc00 + k[3:0], page_perm_e'(k[1:0]));
        end
        for (int p = 0; p < 4; p++) begin
            for (int a = 0; a < 3; a++) begin
                send_req(page_addr(20'h30000 + p[3:0], 12'($random(seed))),
                         page_perm_e'(a[1:0]), BYTE);
            end
        end
        finish_test();

        test_name = "misaligned";
        send_req(page_addr(20'h30003, 12'h001), R, HALF);
        send_req(page_addr(20'h30003, 12'h002), W, WORD);
        send_req(page_addr(20'h30003, 12'h003), W, WORD);
        send_req(page_addr(20'h4aaaa, 12'h005), R, HALF);  // Absent page
        send_req(page_addr(20'h4aaaa, 12'h001), EX, WORD);
        send_req(page_addr(20'h30003, 12'h002), R, HALF);  // Aligned controls
        send_req(page_addr(20'h30003, 12'h007), R, BYTE);
        finish_test();

        test_name = "invalidate";
        send_invalidate();
        for (int k = 0; k < 4; k++) begin
            send_req(page_addr(20'h30000 + k[3:0], 12'h100), R, WORD);
        end
        for (int k = 0; k < 5; k++) begin
            send_refill(20'h50000 + k[3:0], 12'hd00 + k[3:0], RW);
        end
        send_req(page_addr(20'h50000, 12'h200), R, WORD);  // Overwritten by the fifth refill
        send_req(page_addr(20'h50001, 12'h204), W, WORD);
        send_req(page_addr(20'h50004, 12'h208), R, WORD);
        entry.vpn  = 20'h60000;
        entry.ppn  = 12'he00;
        entry.perm = RW;
        drive_cycle(1'b0, '0, R, BYTE, 1'b1, entry, 1'b1);
        send_req(page_addr(20'h60000, 12'h000), R, WORD);
        send_req(page_addr(20'h50001, 12'h000), R, WORD);
        finish_test();

        test_name = "random";
        for (int k = 0; k < 200; k++) begin
            ctl   = $random(seed);
            vaddr = $random(seed);
            if (ctl[2:0] != 3'd7) begin
                vaddr[VADDR_SIZE-1:PAGE_OFFSET_SIZE] = POOL_BASE + VPN_SIZE'(ctl[5:3]);
            end
            // Slot p only ever holds page p or p+4, so no page sits in two rows
            entry.vpn  = POOL_BASE + VPN_SIZE'(shadow_ptr)
                       + (ctl[6] ? VPN_SIZE'(NUM_ENTRIES) : '0);
            entry.ppn  = ctl[19:8];
            entry.perm = page_perm_e'(ctl[21:20]);
            drive_cycle(1'b1, vaddr, page_perm_e'(ctl[23:22] % 2'd3),
                        access_size_e'(ctl[25:24] % 2'd3), ctl[27:26] == 2'b00, entry, 1'b0);
        end
        finish_test();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : mmu_tb
